/* include/audgen_settings.svh */
/*
  Global constants for the audio tone generator.
  Include this file wherever sample, slot, divider, buffer or period sizes are needed.
*/

`ifndef AUDGEN_SETTINGS_SVH
`define AUDGEN_SETTINGS_SVH

// bits per audio sample, one channel
`define AUDGEN_SAMPLE_W 16

// bit slots per channel in one i2s frame
`define AUDGEN_SLOT_W 32

// mclk cycles per bit clock period
`define AUDGEN_SCLK_DIV 4

// sample buffer depth, in stereo samples
`define AUDGEN_FIFO_DEPTH 4

// width of the tone half-period counter
`define AUDGEN_PERIOD_W 8

`endif

/* rtl/audgen_pkg.sv */
/*
  Shared packed types for the audio tone path.
  Import into module bodies, or use scoped names in port lists.
*/

`include "audgen_settings.svh"

package audgen_pkg;

  // one stereo sample, left in the upper half
  typedef struct packed {
    logic [`AUDGEN_SAMPLE_W-1:0] left;
    logic [`AUDGEN_SAMPLE_W-1:0] right;
  } stereo_sample_t;

  // tone setup, held stable while reset is active
  typedef struct packed {
    // samples per half cycle
    logic [`AUDGEN_PERIOD_W-1:0] half_period;
    // sample value in the high half
    logic [`AUDGEN_SAMPLE_W-1:0] amplitude;
  } tone_cfg_t;

  // serial audio pins
  typedef struct packed {
    logic sclk;
    logic lrck;
    logic dac;
  } i2s_out_t;

endpackage

/* rtl/tone_osc.sv */
/*
  Square-wave tone source. Offers stereo samples on a valid/ready port.
  Level is low for half_period samples, then amplitude for half_period samples.
  The tone is not centered, so the low half carries zero.
*/

`timescale 1ns/1ps

`include "audgen_settings.svh"

module tone_osc (
  input  logic                       audgen_mclk,
  input  logic                       reset_n,
  input  audgen_pkg::tone_cfg_t      cfg,
  output audgen_pkg::stereo_sample_t push_data,
  output logic                       push_valid,
  input  logic                       push_ready
);

  // accepted samples within the current half cycle
  logic [`AUDGEN_PERIOD_W-1:0] half_cnt;
  // current wave level
  logic                        level;
  logic                        push_fire;
  logic                        half_done;

  assign push_fire = push_valid && push_ready;
  // last sample of this half cycle
  assign half_done = (half_cnt == cfg.half_period - 1'b1);

  ////////////////////
  // sample counter and level flag
  ////////////////////
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      half_cnt   <= '0;
      level      <= 1'b0;
      push_valid <= 1'b0;
    end else begin
      // source never runs dry once out of reset
      push_valid <= 1'b1;
      if (push_fire) begin
        if (half_done) begin
          half_cnt <= '0;
          level    <= ~level;
        end else begin
          half_cnt <= half_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // sample value
  ////////////////////
  // only changes after a transfer, so it holds while stalled
  always_comb begin
    push_data.left  = level ? cfg.amplitude : '0;
    push_data.right = level ? cfg.amplitude : '0;
  end

endmodule

/* rtl/sample_fifo.sv */
/*
  Small circular buffer for stereo samples.
  Writes take a valid/ready handshake. Reads show the oldest entry
  directly and are removed by a one-cycle pop.
*/

`timescale 1ns/1ps

module sample_fifo #(
  parameter int depth = 4
) (
  input  logic                       audgen_mclk,
  input  logic                       reset_n,
  input  audgen_pkg::stereo_sample_t push_data,
  input  logic                       push_valid,
  output logic                       push_ready,
  output audgen_pkg::stereo_sample_t pop_data,
  output logic                       pop_valid,
  input  logic                       pop
);

  import audgen_pkg::*;

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  stereo_sample_t   mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // entries held
  logic [cnt_w-1:0] count;
  logic             push_fire;
  logic             pop_fire;

  // not full / not empty
  assign push_ready = (count != cnt_w'(depth));
  assign pop_valid  = (count != '0);
  assign push_fire  = push_valid && push_ready;
  // pop is ignored when empty
  assign pop_fire   = pop && pop_valid;

  // oldest entry, no read latency
  assign pop_data = mem[rd_ptr];

  // storage
  always_ff @(posedge audgen_mclk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////
  // pointers and occupancy
  ////////////////////
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/i2s_serializer.sv */
/*
  I2S transmitter. Divides mclk down to the bit clock, pops one stereo
  sample per frame and shifts it out msb first after the one-slot delay.
  Waits for the first sample, then runs frames back to back.
*/

`timescale 1ns/1ps

`include "audgen_settings.svh"

module i2s_serializer (
  input  logic                       audgen_mclk,
  input  logic                       reset_n,
  input  audgen_pkg::stereo_sample_t pop_data,
  input  logic                       pop_valid,
  output logic                       pop,
  output audgen_pkg::i2s_out_t       i2s,
  output logic                       underrun
);

  localparam int div_w   = $clog2(`AUDGEN_SCLK_DIV);
  // bit slots in a stereo frame
  localparam int frame_w = 2 * `AUDGEN_SLOT_W;
  localparam int cnt_w   = $clog2(frame_w);
  // zero slots after the data bits of a channel
  localparam int pad_w   = `AUDGEN_SLOT_W - `AUDGEN_SAMPLE_W - 1;

  logic [div_w-1:0]   div;
  // slot within the frame, msb is the channel
  logic [cnt_w-1:0]   slot_cnt;
  logic               running;
  logic [frame_w-1:0] frame_sr;
  logic [frame_w-1:0] next_frame;
  logic               bit_end;
  logic               frame_end;
  logic               start;

  // last mclk of a bit period, next edge drops sclk
  assign bit_end   = running && (div == div_w'(`AUDGEN_SCLK_DIV - 1));
  assign frame_end = bit_end && (slot_cnt == cnt_w'(frame_w - 1));
  // first sample in the buffer
  assign start     = !running && pop_valid;
  assign pop       = start || (frame_end && pop_valid);

  // frame image, delay slot + data + zero pad per channel
  // silent frame on underrun
  always_comb begin
    next_frame = '0;
    if (pop_valid) begin
      next_frame = {1'b0, pop_data.left, {pad_w{1'b0}},
                    1'b0, pop_data.right, {pad_w{1'b0}}};
    end
  end

  ////////////////////
  // bit clock, slot counter and shifter
  ////////////////////
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      div      <= '0;
      slot_cnt <= '0;
      running  <= 1'b0;
      frame_sr <= '0;
      underrun <= 1'b0;
    end else begin
      if (running) begin
        div <= bit_end ? '0 : div + 1'b1;
      end
      if (bit_end) begin
        slot_cnt <= slot_cnt + 1'b1;
      end
      if (start) begin
        running  <= 1'b1;
        frame_sr <= next_frame;
      end else if (frame_end) begin
        frame_sr <= next_frame;
        // sticky until reset
        if (!pop_valid) begin
          underrun <= 1'b1;
        end
      end else if (bit_end) begin
        frame_sr <= frame_sr << 1;
      end
    end
  end

  // lrck and dac move together with the falling sclk
  always_comb begin
    i2s.sclk = div[div_w-1];
    i2s.lrck = slot_cnt[cnt_w-1];
    i2s.dac  = frame_sr[frame_w-1];
  end

endmodule

/* rtl/audgen_top.sv */
/*
  Audio tone path top level.
  Tone source feeds the sample buffer, the I2S transmitter drains it.
  tone_cfg must be stable while reset_n is low.
*/

`timescale 1ns/1ps

`include "audgen_settings.svh"

module audgen_top (
  input  logic                  audgen_mclk,
  input  logic                  reset_n,
  input  audgen_pkg::tone_cfg_t tone_cfg,
  output audgen_pkg::i2s_out_t  i2s,
  output logic                  underrun
);

  import audgen_pkg::*;

  // source to buffer
  stereo_sample_t push_data;
  logic           push_valid;
  logic           push_ready;
  // buffer to transmitter
  stereo_sample_t pop_data;
  logic           pop_valid;
  logic           pop;

  tone_osc u_tone_osc (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .cfg         (tone_cfg),
    .push_data   (push_data),
    .push_valid  (push_valid),
    .push_ready  (push_ready)
  );

  sample_fifo #(
    .depth (`AUDGEN_FIFO_DEPTH)
  ) u_sample_fifo (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .push_data   (push_data),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .pop_data    (pop_data),
    .pop_valid   (pop_valid),
    .pop         (pop)
  );

  i2s_serializer u_i2s_serializer (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .pop_data    (pop_data),
    .pop_valid   (pop_valid),
    .pop         (pop),
    .i2s         (i2s),
    .underrun    (underrun)
  );

endmodule

/* verif/tb_audgen.sv */
/*
  Self-checking testbench for the audio tone path.
  Each line of verif/audgen_stim.txt resets the DUT with one tone setup,
  then the I2S stream is decoded and checked for samples, padding and timing.
*/

`timescale 1ns/1ps

`include "audgen_settings.svh"

module tb_audgen;

  import audgen_pkg::*;

  localparam int clk_period   = 10;
  localparam int max_tests    = 32;
  localparam int slot_w       = `AUDGEN_SLOT_W;
  localparam int sample_w     = `AUDGEN_SAMPLE_W;
  // mclk cycles per stereo frame
  localparam int frame_cycles = 2 * slot_w * `AUDGEN_SCLK_DIV;

  logic      audgen_mclk;
  logic      reset_n;
  tone_cfg_t tone_cfg;
  i2s_out_t  i2s;
  logic      underrun;
  logic      sclk;
  logic      lrck;
  logic      dac;

  // test table from the stim file
  logic [8*32-1:0]       t_name [max_tests];
  int                    t_half [max_tests];
  logic [sample_w-1:0]   t_amp [max_tests];
  int                    t_frames [max_tests];
  int                    t_high [max_tests];
  int                    n_tests;
  logic [8*32-1:0]       test_name;
  int                    timeout_cycles = 0;
  // edge timing history
  longint                sclk_last;
  longint                lrck_last;
  logic                  sclk_seen;
  logic                  lrck_seen;

  assign sclk = i2s.sclk;
  assign lrck = i2s.lrck;
  assign dac  = i2s.dac;

  audgen_top UUT (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .tone_cfg    (tone_cfg),
    .i2s         (i2s),
    .underrun    (underrun)
  );

  initial begin
    audgen_mclk = 1'b0;
    forever #(clk_period / 2) audgen_mclk = ~audgen_mclk;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: test %0s, %0s: expected %0h, actual %0h",
               test_name, what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////
  // stim file reader
  ////////////////////
  task automatic load_tests();
    int              fd;
    int              n;
    logic [8*128-1:0] line;
    logic [8*32-1:0] name;
    int              hp;
    int              frames;
    int              high;
    logic [sample_w-1:0] amp;
    fd = $fopen("verif/audgen_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/audgen_stim.txt for reading");
      $display("** FAIL **");
      $fatal(1, "no stimulus");
    end
    n_tests = 0;
    while (!$feof(fd)) begin
      line = '0;
      n = $fgets(line, fd);
      // comment and blank lines never give five fields
      if (n > 0 && $sscanf(line, "%s %d %h %d %d", name, hp, amp, frames, high) == 5
          && n_tests < max_tests) begin
        t_name[n_tests]   = name;
        t_half[n_tests]   = hp;
        t_amp[n_tests]    = amp;
        t_frames[n_tests] = frames;
        t_high[n_tests]   = high;
        n_tests++;
      end
    end
    $fclose(fd);
    if (n_tests == 0) begin
      $display("the stim file holds no test lines");
      $display("** FAIL **");
      $fatal(1, "no stimulus");
    end
  endtask

  // 8 cycles of reset with the new setup, outputs quiet throughout
  task automatic reset_dut(input tone_cfg_t cfg);
    int i;
    @(posedge audgen_mclk);
    #1;
    reset_n  = 1'b0;
    tone_cfg = cfg;
    for (i = 0; i < 8; i++) begin
      @(negedge audgen_mclk);
      check_value("outputs in reset", 4'b0, {sclk, lrck, dac, underrun});
      @(posedge audgen_mclk);
    end
    #1;
    reset_n = 1'b1;
    @(negedge audgen_mclk);
    check_value("outputs after reset", 4'b0, {sclk, lrck, dac, underrun});
  endtask

  ////////////////////
  // I2S receiver
  ////////////////////
  // one frame, sampled on rising sclk where dac and lrck are settled
  task automatic receive_frame(output logic [sample_w-1:0] left,
                               output logic [sample_w-1:0] right);
    int slot;
    int ch_slot;
    logic [sample_w-1:0] l_word;
    logic [sample_w-1:0] r_word;
    l_word = '0;
    r_word = '0;
    for (slot = 0; slot < 2 * slot_w; slot++) begin
      @(posedge sclk);
      ch_slot = slot % slot_w;
      check_value($sformatf("lrck in slot %0d", slot), slot >= slot_w, lrck);
      check_value("underrun", 1'b0, underrun);
      // slots 1 to 16 hold data msb first
      if (ch_slot >= 1 && ch_slot <= sample_w) begin
        if (slot < slot_w) l_word = {l_word[sample_w-2:0], dac};
        else r_word = {r_word[sample_w-2:0], dac};
      end else begin
        check_value($sformatf("pad slot %0d", slot), 1'b0, dac);
      end
    end
    left  = l_word;
    right = r_word;
  endtask

  task automatic run_test(input int idx);
    tone_cfg_t           cfg;
    logic [sample_w-1:0] left;
    logic [sample_w-1:0] right;
    logic [sample_w-1:0] exp;
    int                  n;
    int                  high;
    test_name       = t_name[idx];
    cfg.half_period = t_half[idx];
    cfg.amplitude   = t_amp[idx];
    reset_dut(cfg);
    high = 0;
    for (n = 0; n < t_frames[idx]; n++) begin
      receive_frame(left, right);
      // low half first, odd half-cycles carry the amplitude
      exp = ((n / t_half[idx]) % 2 == 1) ? t_amp[idx] : '0;
      check_value($sformatf("frame %0d left", n), exp, left);
      check_value($sformatf("frame %0d right vs left", n), left, right);
      if (left == t_amp[idx]) high++;
    end
    check_value("high frame count", t_high[idx], high);
  endtask

  ////////////////////
  // clock timing monitors
  ////////////////////
  always @(sclk or negedge reset_n) begin
    if (reset_n !== 1'b1) begin
      sclk_seen = 1'b0;
    end else begin
      if (sclk_seen)
        check_value("sclk half period", clk_period * `AUDGEN_SCLK_DIV / 2, $time - sclk_last);
      sclk_seen = 1'b1;
      sclk_last = $time;
    end
  end

  // one channel per lrck level
  always @(lrck or negedge reset_n) begin
    if (reset_n !== 1'b1) begin
      lrck_seen = 1'b0;
    end else begin
      if (lrck_seen)
        check_value("lrck half period", clk_period * frame_cycles / 2, $time - lrck_last);
      lrck_seen = 1'b1;
      lrck_last = $time;
    end
  end

  // watchdog, armed once the test lengths are known
  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge audgen_mclk);
    $display("timeout: the run did not finish within %0d mclk cycles", timeout_cycles);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin : main_flow
    int first_rand;
    int gap;
    int i;
    reset_n    = 1'b0;
    tone_cfg   = '0;
    first_rand = $urandom(32'h0da3b19e);
    load_tests();
    // frames plus reset, startup and idle gap per test
    for (i = 0; i < n_tests; i++)
      timeout_cycles += (t_frames[i] + 1) * frame_cycles + 48;
    timeout_cycles += 1000;
    for (i = 0; i < n_tests; i++) begin
      run_test(i);
      gap = $urandom % 16;
      repeat (gap) @(posedge audgen_mclk);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
rtl/audgen_pkg.sv
rtl/tone_osc.sv
rtl/sample_fifo.sv
rtl/i2s_serializer.sv
rtl/audgen_top.sv
verif/tb_audgen.sv

/* Bender.yml */
package:
  name: audgen

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/audgen_pkg.sv
      - rtl/tone_osc.sv
      - rtl/sample_fifo.sv
      - rtl/i2s_serializer.sv
      - rtl/audgen_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_audgen.sv

/* verif/audgen_stim.txt */
# columns: test name, half period (dec), amplitude (hex), frames to check (dec),
# expected high frames (dec); the tone starts low, odd half-cycles are high
basic_hp2        2    1000  16  8
toggle_hp1       1    7fff  10  5
odd_hp3          3    8001  14  6
small_amp_hp5    5    0123  20  10
full_scale_hp4   4    ffff  13  5
partial_hp7      7    4a5c  12  5
long_hp16        16   0002  40  16
all_low_hp200    200  5555  6   0
